// File: cpu_core.f
+incdir+design
design/cpu_pkg.sv
design/decode_if.sv
design/cpu_alu.sv
design/program_counter.sv
design/cpu_sequencer.sv
design/register_file.sv
design/instr_decoder.sv
design/cpu_core.sv
test/tb_memory.sv
test/cpu_core_tb.sv

// File: design/cpu_alu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_alu (
    input  cpu_pkg::alu_op_t  alu_op,
    input  cpu_pkg::byte_t    a_in,
    input  cpu_pkg::byte_t    b_in,
    input  logic              carry_in,
    output cpu_pkg::byte_t    result,
    output logic              n_out,
    output logic              v_out,
    output logic              z_out,
    output logic              c_out
);
    import cpu_pkg::*;

    byte_t                 b_eff;  // Adder operand, inverted for subtract
    logic                  c_eff;  // Adder carry in
    logic [`CPU_DATA_W:0]  sum;    // Adder with carry out on top

    always_comb begin
        b_eff = b_in;
        c_eff = carry_in;
        case (alu_op)
            ALU_SBC: b_eff = ~b_in;
            ALU_CMP: begin
                b_eff = ~b_in;
                c_eff = 1'b1;          // Compare ignores C
            end
            default: ;
        endcase
    end

    assign sum = {1'b0, a_in} + {1'b0, b_eff} + {{`CPU_DATA_W{1'b0}}, c_eff};

    always_comb begin
        case (alu_op)
            ALU_OR:                    result = a_in | b_in;
            ALU_AND:                   result = a_in & b_in;
            ALU_EOR:                   result = a_in ^ b_in;
            ALU_ADC, ALU_SBC, ALU_CMP: result = sum[`CPU_DATA_W-1:0];
            ALU_INC:                   result = a_in + byte_t'(1);
            ALU_DEC:                   result = a_in - byte_t'(1);
            default:                   result = b_in;    // Loads pass din
        endcase
    end

    assign n_out = result[`CPU_DATA_W-1];
    assign z_out = (result == '0);
    assign c_out = sum[`CPU_DATA_W];       // Also the not-borrow of SBC/CMP
    // Same-sign inputs giving a result of the other sign
    assign v_out = (a_in[`CPU_DATA_W-1] == b_eff[`CPU_DATA_W-1]) &&
                   (sum[`CPU_DATA_W-1] != a_in[`CPU_DATA_W-1]);

endmodule

// File: design/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic              clk,
    input  logic              reset,
    output cpu_pkg::addr_t    addr,
    input  cpu_pkg::byte_t    din,
    output cpu_pkg::byte_t    dout,
    output logic              we,
    input  logic              rdy
);
    import cpu_pkg::*;

    addr_t  pc;
    pc_op_t pc_op;
    logic   ir_load;           // Opcode on din
    logic   exec_strobe;       // Last cycle of a register or flag update
    logic   cond_true;         // Branch taken

    decode_if dec_bus ();

    cpu_sequencer seq0 (
        .clk         (clk),
        .reset       (reset),
        .rdy         (rdy),
        .din         (din),
        .pc          (pc),
        .dec         (dec_bus.sequencer),
        .cond_true   (cond_true),
        .addr        (addr),
        .we          (we),
        .pc_op       (pc_op),
        .ir_load     (ir_load),
        .exec_strobe (exec_strobe)
    );

    program_counter pc0 (
        .clk   (clk),
        .reset (reset),
        .rdy   (rdy),
        .pc_op (pc_op),
        .din   (din),
        .pc    (pc)
    );

    register_file regs0 (
        .clk         (clk),
        .reset       (reset),
        .rdy         (rdy),
        .exec_strobe (exec_strobe),
        .din         (din),
        .dec         (dec_bus.datapath),
        .dout        (dout),
        .cond_true   (cond_true)
    );

    instr_decoder dec0 (
        .clk     (clk),
        .reset   (reset),
        .rdy     (rdy),
        .ir_load (ir_load),
        .din     (din),
        .dec     (dec_bus.decoder)
    );

endmodule

// File: design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bus widths
`define CPU_DATA_W 8                 // Data bus and register width
`define CPU_ADDR_W 16                // Address bus width

// Fixed addresses
`define CPU_RESET_VECTOR 16'hFFFC    // Vector low byte with the high byte after it
`define CPU_ZERO_PAGE 8'h00          // Upper address byte for zp accesses

// The core fetches the vector in two reads
// and starts at the address found there.
// Zero-page operands form the low address byte
// with CPU_ZERO_PAGE above them.

`endif

// File: design/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] byte_t;    // Data byte
    typedef logic [`CPU_ADDR_W-1:0] addr_t;    // Bus address

    typedef enum logic [1:0] {
        REG_A,                                 // Accumulator
        REG_X,                                 // Index X
        REG_Y                                  // Index Y
    } reg_sel_t;

    typedef enum logic [3:0] {
        ALU_OR,
        ALU_AND,
        ALU_EOR,
        ALU_ADC,                               // Add with carry
        ALU_SBC,                               // Add inverted operand with carry
        ALU_CMP,                               // Subtract with carry forced
        ALU_INC,                               // Register plus one
        ALU_DEC,                               // Register minus one
        ALU_PASS                               // Forward operand for loads
    } alu_op_t;

    typedef enum logic [2:0] {
        MODE_IMPLIED,
        MODE_IMMEDIATE,
        MODE_ZERO_PAGE,
        MODE_JUMP,                             // JMP absolute
        MODE_BRANCH                            // Relative conditional branch
    } addr_mode_t;

    typedef enum logic [2:0] {
        PC_HOLD,
        PC_INC,
        PC_LATCH_LO,                           // Keep din as target low byte
        PC_LOAD,                               // Jump to {din, latched low}
        PC_BRANCH                              // Relative offset from din
    } pc_op_t;

    typedef enum logic [1:0] {FLAG_NONE, FLAG_CLC, FLAG_SEC} flag_op_t;

    typedef enum logic [2:0] {
        ST_VEC_LO, ST_VEC_HI, ST_OPCODE, ST_OPERAND, ST_EXECUTE, ST_ZP_ACCESS, ST_JMP_HI
    } cpu_state_t;

endpackage

// File: design/cpu_sequencer.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              rdy,
    input  cpu_pkg::byte_t    din,
    input  cpu_pkg::addr_t    pc,
    decode_if.sequencer       dec,
    input  logic              cond_true,
    output cpu_pkg::addr_t    addr,
    output logic              we,
    output cpu_pkg::pc_op_t   pc_op,
    output logic              ir_load,
    output logic              exec_strobe
);
    import cpu_pkg::*;

    cpu_state_t state;         // Current bus cycle
    cpu_state_t state_next;
    addr_mode_t mode_q;        // Mode of the instruction in flight
    byte_t      zp_addr;       // Zero-page operand address

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= ST_VEC_LO;
            mode_q <= MODE_IMPLIED;
        end else if (rdy) begin
            state <= state_next;
            if (ir_load) begin
                mode_q <= dec.mode;        // din is the opcode here
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && state == ST_OPERAND) begin
            zp_addr <= din;                // Only used by zero-page mode
        end
    end

    assign ir_load = (state == ST_OPCODE);

    always_comb begin
        state_next  = state;
        addr        = pc;                  // Most cycles read at PC
        we          = 1'b0;
        pc_op       = PC_HOLD;
        exec_strobe = 1'b0;
        case (state)
            ST_VEC_LO: begin
                addr       = `CPU_RESET_VECTOR;
                pc_op      = PC_LATCH_LO;
                state_next = ST_VEC_HI;
            end
            ST_VEC_HI: begin
                addr       = `CPU_RESET_VECTOR + addr_t'(1);
                pc_op      = PC_LOAD;      // PC takes the vector
                state_next = ST_OPCODE;
            end
            ST_OPCODE: begin
                pc_op      = PC_INC;
                state_next = (dec.mode == MODE_IMPLIED) ? ST_EXECUTE : ST_OPERAND;
            end
            ST_OPERAND: begin
                state_next = ST_OPCODE;
                case (mode_q)
                    MODE_IMMEDIATE: begin
                        pc_op       = PC_INC;
                        exec_strobe = dec.load_reg;    // Operand is din now
                    end
                    MODE_ZERO_PAGE: begin
                        pc_op      = PC_INC;
                        state_next = ST_ZP_ACCESS;
                    end
                    MODE_JUMP: begin
                        pc_op      = PC_LATCH_LO;      // Target low byte
                        state_next = ST_JMP_HI;
                    end
                    MODE_BRANCH: pc_op = cond_true ? PC_BRANCH : PC_INC;
                    default:     pc_op = PC_INC;
                endcase
            end
            ST_ZP_ACCESS: begin
                addr        = {`CPU_ZERO_PAGE, zp_addr};
                we          = dec.store;               // Only store cycle writes
                exec_strobe = dec.load_reg;
                state_next  = ST_OPCODE;
            end
            ST_JMP_HI: begin
                pc_op      = PC_LOAD;
                state_next = ST_OPCODE;
            end
            ST_EXECUTE: begin
                exec_strobe = 1'b1;        // Dummy read at PC
                state_next  = ST_OPCODE;
            end
            default: state_next = ST_VEC_LO;
        endcase
    end

endmodule

// File: design/decode_if.sv
`timescale 1ns/1ps

interface decode_if;
    import cpu_pkg::*;

    addr_mode_t mode;        // From din while the opcode is on the bus
    reg_sel_t   src_reg;     // Register feeding the ALU and dout
    reg_sel_t   dst_reg;     // Register written on exec_strobe
    alu_op_t    alu_op;
    logic       load_reg;    // Operand goes through the ALU
    logic       store;       // STA/STX/STY
    flag_op_t   flag_op;     // CLC/SEC
    logic [2:0] cond;        // Flag select and polarity for branches

    modport decoder (
        output mode, src_reg, dst_reg, alu_op, load_reg, store, flag_op, cond
    );

    modport sequencer (
        input mode, store, load_reg
    );

    modport datapath (
        input src_reg, dst_reg, alu_op, load_reg, flag_op, cond
    );

endinterface

// File: design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              rdy,
    input  logic              ir_load,
    input  cpu_pkg::byte_t    din,
    decode_if.decoder         dec
);
    import cpu_pkg::*;

    reg_sel_t src_d, dst_d;
    alu_op_t  op_d;
    logic     load_d, store_d;
    flag_op_t flag_d;

    always_comb begin
        case (din)
            8'hA9, 8'hA2, 8'hA0, 8'h09, 8'h29, 8'h49, 8'h69, 8'hC9, 8'hE9:
                dec.mode = MODE_IMMEDIATE;
            8'hA5, 8'hA6, 8'hA4, 8'h85, 8'h86, 8'h84,
            8'h05, 8'h25, 8'h45, 8'h65, 8'hC5, 8'hE5:
                dec.mode = MODE_ZERO_PAGE;
            8'h4C:   dec.mode = MODE_JUMP;
            8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0:
                dec.mode = MODE_BRANCH;
            default: dec.mode = MODE_IMPLIED;   // Unknown opcodes too
        endcase
    end

    always_comb begin
        src_d   = REG_A;
        dst_d   = REG_A;
        op_d    = ALU_PASS;
        load_d  = 1'b0;
        store_d = 1'b0;
        flag_d  = FLAG_NONE;
        case (din)
            8'h09, 8'h05, 8'h29, 8'h25, 8'h49, 8'h45,
            8'h69, 8'h65, 8'hC9, 8'hC5, 8'hE9, 8'hE5: begin
                load_d = 1'b1;
                case (din[7:5])                 // Operation in aaa bits
                    3'b000:  op_d = ALU_OR;
                    3'b001:  op_d = ALU_AND;
                    3'b010:  op_d = ALU_EOR;
                    3'b011:  op_d = ALU_ADC;
                    3'b110:  op_d = ALU_CMP;
                    default: op_d = ALU_SBC;
                endcase
            end
            8'hA9, 8'hA5: load_d = 1'b1;                        // LDA
            8'hA2, 8'hA6: begin load_d = 1'b1; dst_d = REG_X; end
            8'hA0, 8'hA4: begin load_d = 1'b1; dst_d = REG_Y; end
            8'h85: store_d = 1'b1;                              // STA
            8'h86: begin store_d = 1'b1; src_d = REG_X; end
            8'h84: begin store_d = 1'b1; src_d = REG_Y; end
            8'hE8: begin load_d = 1'b1; src_d = REG_X; dst_d = REG_X; op_d = ALU_INC; end
            8'hC8: begin load_d = 1'b1; src_d = REG_Y; dst_d = REG_Y; op_d = ALU_INC; end
            8'hCA: begin load_d = 1'b1; src_d = REG_X; dst_d = REG_X; op_d = ALU_DEC; end
            8'h88: begin load_d = 1'b1; src_d = REG_Y; dst_d = REG_Y; op_d = ALU_DEC; end
            8'h18: flag_d = FLAG_CLC;
            8'h38: flag_d = FLAG_SEC;
            default: ;                          // No effect
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec.src_reg  <= REG_A;
            dec.dst_reg  <= REG_A;
            dec.alu_op   <= ALU_PASS;
            dec.load_reg <= 1'b0;
            dec.store    <= 1'b0;
            dec.flag_op  <= FLAG_NONE;
            dec.cond     <= 3'b000;
        end else if (rdy && ir_load) begin
            dec.src_reg  <= src_d;
            dec.dst_reg  <= dst_d;
            dec.alu_op   <= op_d;
            dec.load_reg <= load_d;
            dec.store    <= store_d;
            dec.flag_op  <= flag_d;
            dec.cond     <= din[7:5];           // Branch flag and polarity
        end
    end

endmodule

// File: design/program_counter.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module program_counter (
    input  logic              clk,
    input  logic              reset,
    input  logic              rdy,
    input  cpu_pkg::pc_op_t   pc_op,
    input  cpu_pkg::byte_t    din,
    output cpu_pkg::addr_t    pc
);
    import cpu_pkg::*;

    byte_t lo_latch;           // Low byte of a jump target
    addr_t offset;             // Sign-extended branch offset

    assign offset = {{(`CPU_ADDR_W - `CPU_DATA_W){din[`CPU_DATA_W-1]}}, din};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (rdy) begin
            case (pc_op)
                PC_INC, PC_LATCH_LO: pc <= pc + addr_t'(1);
                PC_LOAD:             pc <= {din, lo_latch};
                PC_BRANCH:           pc <= pc + addr_t'(1) + offset;  // From next opcode
                default:             pc <= pc;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && pc_op == PC_LATCH_LO) begin
            lo_latch <= din;
        end
    end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic              clk,
    input  logic              reset,
    input  logic              rdy,
    input  logic              exec_strobe,
    input  cpu_pkg::byte_t    din,
    decode_if.datapath        dec,
    output cpu_pkg::byte_t    dout,
    output logic              cond_true
);
    import cpu_pkg::*;

    byte_t a_reg, x_reg, y_reg;
    byte_t src_val;                        // Selected source register
    byte_t alu_result;
    logic  flag_n, flag_v, flag_z, flag_c;
    logic  alu_n, alu_v, alu_z, alu_c;
    logic  carry_op;                       // ADC/SBC/CMP set C
    logic  ovf_op;                         // ADC/SBC set V
    logic  write_reg;
    logic  flag_sel;

    always_comb begin
        case (dec.src_reg)
            REG_X:   src_val = x_reg;
            REG_Y:   src_val = y_reg;
            default: src_val = a_reg;
        endcase
    end

    cpu_alu alu0 (
        .alu_op   (dec.alu_op),
        .a_in     (src_val),
        .b_in     (din),               // Immediate or zero-page operand
        .carry_in (flag_c),
        .result   (alu_result),
        .n_out    (alu_n),
        .v_out    (alu_v),
        .z_out    (alu_z),
        .c_out    (alu_c)
    );

    assign carry_op  = (dec.alu_op == ALU_ADC) || (dec.alu_op == ALU_SBC) ||
                       (dec.alu_op == ALU_CMP);
    assign ovf_op    = (dec.alu_op == ALU_ADC) || (dec.alu_op == ALU_SBC);
    assign write_reg = exec_strobe && dec.load_reg && (dec.alu_op != ALU_CMP);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_reg <= '0;
            x_reg <= '0;
            y_reg <= '0;
        end else if (rdy && write_reg) begin
            case (dec.dst_reg)
                REG_X:   x_reg <= alu_result;
                REG_Y:   y_reg <= alu_result;
                default: a_reg <= alu_result;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {flag_n, flag_v, flag_z, flag_c} <= 4'b0000;
        end else if (rdy && exec_strobe) begin
            if (dec.load_reg) begin
                flag_n <= alu_n;
                flag_z <= alu_z;
                if (carry_op) flag_c <= alu_c;
                if (ovf_op)   flag_v <= alu_v;
            end
            case (dec.flag_op)
                FLAG_CLC: flag_c <= 1'b0;
                FLAG_SEC: flag_c <= 1'b1;
                default:  ;
            endcase
        end
    end

    assign dout = src_val;                 // Store data

    always_comb begin
        case (dec.cond[2:1])
            2'b00:   flag_sel = flag_n;    // BPL/BMI
            2'b01:   flag_sel = flag_v;    // BVC/BVS
            2'b10:   flag_sel = flag_c;    // BCC/BCS
            default: flag_sel = flag_z;    // BNE/BEQ
        endcase
        cond_true = (flag_sel == dec.cond[0]);
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the cpu_core testbench with Verilator

verilator --binary --timing -Wno-fatal -f cpu_core.f --top-module cpu_core_tb -o sim_cpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation run failed"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    exit 1
fi
exit 0

// File: test/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;
    import cpu_pkg::*;

    localparam addr_t ORG = 16'h0200;  // Program start held in the vector

    logic  clk, reset, rdy, we, write_strobe;
    addr_t addr, halt_pc;
    byte_t din, dout, zp_next;
    addr_t exp_addr[$];                // Expected stores in order
    byte_t exp_data[$];
    addr_t boot_exp[3];
    int    pc_w, n_instr, errors, stores, boot, cycles, limit;

    cpu_core dut0 (.clk, .reset, .addr, .din, .dout, .we, .rdy);
    tb_memory mem0 (.clk, .reset, .addr, .we, .dout, .din, .rdy, .write_strobe);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Binary 6502 rules returning {C, V, result}
    function automatic logic [9:0] alu_ref(input logic [2:0] op, input byte_t a,
                                           input byte_t b, input logic cin);
        int    diff;
        int    sdiff;
        int    borrow;
        logic  c;
        logic  v;
        byte_t r;
        c = cin;
        v = 1'b0;
        borrow = (op == 3'd6 || cin) ? 0 : 1;   // CMP ignores carry
        case (op)
            3'd0: r = a | b;
            3'd1: r = a & b;
            3'd2: r = a ^ b;
            3'd3: begin
                diff  = int'(a) + int'(b) + int'(cin);
                sdiff = int'($signed(a)) + int'($signed(b)) + int'(cin);
                r = diff[7:0];
                c = (diff > 255);
                v = (sdiff > 127) || (sdiff < -128);
            end
            default: begin             // SBC and CMP
                diff  = int'(a) - int'(b) - borrow;
                sdiff = int'($signed(a)) - int'($signed(b)) - borrow;
                r = diff[7:0];
                c = (diff >= 0);
                v = (op != 3'd6) && ((sdiff > 127) || (sdiff < -128));
            end
        endcase
        return {c, v, r};
    endfunction

    task automatic put(input byte_t b);
        mem0.mem[pc_w] = b;
        pc_w++;
    endtask

    task automatic ins(input byte_t opc);   // Opcode byte of one instruction
        put(opc);
        n_instr++;
    endtask

    task automatic store_to_zp(input byte_t opc, input byte_t val);
        ins(opc);
        put(zp_next);
        exp_addr.push_back({8'h00, zp_next});
        exp_data.push_back(val);
        zp_next = (zp_next == 8'h7F) ? 8'h10 : zp_next + 8'h01;
    endtask

    task automatic build_program();
        logic [9:0] res;
        byte_t      a, b, zp, k;
        logic [2:0] op;
        logic       c, sel;
        pc_w = ORG;
        mem0.mem[16'hFFFC] = ORG[7:0];
        mem0.mem[16'hFFFD] = ORG[15:8];
        for (int blk = 0; blk < 30; blk++) begin
            case (blk % 5)
                0: for (int r = 0; r < 3; r++) begin    // Loads then stores
                    a  = byte_t'($urandom);
                    zp = 8'h80 | byte_t'($urandom);      // Preset data area
                    sel = $urandom_range(1);
                    ins(sel ? byte_t'(8'hA4 + (r == 0 ? 1 : (r == 1 ? 2 : 0)))
                            : byte_t'(r == 0 ? 8'hA9 : (r == 1 ? 8'hA2 : 8'hA0)));
                    put(sel ? zp : a);
                    store_to_zp(r == 0 ? 8'h85 : (r == 1 ? 8'h86 : 8'h84),
                                sel ? mem0.mem[{8'h00, zp}] : a);
                end
                1: begin                                 // ADC or SBC with C/V markers
                    c  = $urandom_range(1);
                    op = $urandom_range(1) ? 3'd7 : 3'd3;
                    a  = byte_t'($urandom);
                    zp = 8'h80 | byte_t'($urandom);
                    sel = $urandom_range(1);
                    b  = sel ? mem0.mem[{8'h00, zp}] : byte_t'($urandom);
                    ins(c ? 8'h38 : 8'h18);
                    ins(8'hA9);
                    put(a);
                    ins({op, 5'b01001} - (sel ? 8'h04 : 8'h00));
                    put(sel ? zp : b);
                    res = alu_ref(op, a, b, c);
                    store_to_zp(8'h85, res[7:0]);
                    sel = $urandom_range(1);             // BVS or BCS
                    ins(8'hA9);
                    put(8'h11);
                    ins(sel ? 8'h70 : 8'hB0);
                    put(8'h02);
                    ins(8'hA9);
                    put(8'h22);
                    store_to_zp(8'h85, (sel ? res[8] : res[9]) ? 8'h11 : 8'h22);
                end
                2: begin                                 // Logic and CMP with BEQ/BMI
                    op = 3'($urandom_range(2));
                    a  = byte_t'($urandom);
                    b  = byte_t'($urandom);
                    ins(8'hA9);
                    put(a);
                    ins({op, 5'b01001});
                    put(b);
                    res = alu_ref(op, a, b, 1'b0);
                    store_to_zp(8'h85, res[7:0]);
                    k = $urandom_range(1) ? res[7:0] : byte_t'($urandom);
                    res = alu_ref(3'd6, res[7:0], k, 1'b0);
                    sel = $urandom_range(1);             // BEQ or BMI
                    ins(8'hA2);
                    put(8'h33);
                    ins(8'hC9);
                    put(k);
                    ins(sel ? 8'hF0 : 8'h30);
                    put(8'h02);
                    ins(8'hA2);
                    put(8'h44);
                    store_to_zp(8'h86, (sel ? (res[7:0] == 0) : res[7]) ? 8'h33 : 8'h44);
                end
                3: begin                                 // Counters
                    a = byte_t'($urandom);
                    b = byte_t'($urandom);
                    sel = $urandom_range(1);
                    ins(8'hA2);
                    put(a);
                    ins(8'hA0);
                    put(b);
                    ins(sel ? 8'hE8 : 8'hCA);
                    ins(sel ? 8'h88 : 8'hC8);
                    store_to_zp(8'h86, sel ? a + 8'h01 : a - 8'h01);
                    store_to_zp(8'h84, sel ? b - 8'h01 : b + 8'h01);
                end
                default: begin                           // JMP then a DEX loop
                    ins(8'hA9);
                    put(8'h77);
                    ins(8'h4C);
                    put(byte_t'(pc_w + 4));
                    put(byte_t'((pc_w + 3) >> 8));
                    put(8'hA9);                          // Skipped LDA #$EE
                    put(8'hEE);
                    store_to_zp(8'h85, 8'h77);
                    k = byte_t'($urandom_range(4, 1));
                    ins(8'hA2);
                    put(k);
                    ins(8'hA9);
                    put(8'h5A);
                    ins(8'h85);
                    put(zp_next);
                    repeat (k) begin
                        exp_addr.push_back({8'h00, zp_next});
                        exp_data.push_back(8'h5A);
                    end
                    zp_next = (zp_next == 8'h7F) ? 8'h10 : zp_next + 8'h01;
                    ins(8'hCA);
                    ins(8'hD0);
                    put(8'hF9);                          // Back to the LDA
                    n_instr += 4 * (k - 1);
                end
            endcase
        end
        halt_pc = addr_t'(pc_w);
        ins(8'h4C);                                      // Jump to itself
        put(halt_pc[7:0]);
        put(halt_pc[15:8]);
    endtask

    // Boot reads and store stream sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            if (we) begin
                errors++;
                $display("Write enable is high during reset");
            end
        end else if (rdy) begin
            if (boot < 3) begin
                if (addr != boot_exp[boot]) begin
                    errors++;
                    $display("Error: addr %h, expected %h at boot read %0d",
                             addr, boot_exp[boot], boot);
                end
                boot++;
            end
            if (write_strobe) begin
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("A store happened after all expected stores");
                end else begin
                    if (addr != exp_addr[0]) begin
                        errors++;
                        $display("Error: addr %h, expected %h", addr, exp_addr[0]);
                    end
                    if (dout != exp_data[0]) begin
                        errors++;
                        $display("Error: dout %h, expected %h", dout, exp_data[0]);
                    end
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                    stores++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout after %0d cycles, %0d stores seen", cycles, stores);
                $display("Simulation FAILED");
                $finish;
            end
        end
    end

    initial begin
        void'($urandom(96));
        reset    = 1'b1;
        errors   = 0;
        stores   = 0;
        boot     = 0;
        cycles   = 0;
        n_instr  = 0;
        zp_next  = 8'h10;
        boot_exp = '{16'hFFFC, 16'hFFFD, ORG};
        #1;
        build_program();
        limit = n_instr * 3 * 2 + 100;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        @(negedge clk);
        while (!(exp_addr.size() == 0 && rdy && addr == halt_pc)) begin
            @(negedge clk);
        end
        @(posedge clk);
        $display("Stores checked %0d, errors %0d", stores, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: test/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::addr_t    addr,
    input  logic              we,
    input  cpu_pkg::byte_t    dout,
    output cpu_pkg::byte_t    din,
    output logic              rdy,
    output logic              write_strobe
);
    import cpu_pkg::*;

    byte_t mem [0:65535];              // Full 64K address space
    logic  reset_seen;                 // Reset as seen at the clock edge

    initial begin
        rdy = 1'b1;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = byte_t'(i ^ (i >> 8) ^ 8'h5A);    // Depends on both address bytes
        end
    end

    assign din          = mem[addr];   // Combinational read
    assign write_strobe = we && rdy;   // A write really takes place

    always @(posedge clk) begin
        if (write_strobe) begin
            mem[addr] <= dout;
        end
    end

    // Random wait states about one cycle in four
    always @(posedge clk) begin
        reset_seen = reset;
        #2;
        if (reset_seen) begin
            rdy <= 1'b1;
        end else begin
            rdy <= ($urandom_range(3) != 0);
        end
    end

endmodule
